//--- zynq_shell_pkg.sv
package zynq_shell_pkg;

  // bus geometry
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_ADDR_W = 10;
  localparam int WORD_ADDR_W = AXIL_ADDR_W - 2;

  localparam int NUM_CTRL_REGS = 5;
  localparam int NUM_STAT_REGS = 2;
  localparam int NUM_FIFOS     = 2;

  typedef logic [AXIL_DATA_W-1:0] axil_word_t;

  //////////////////////////////////////////////////
  // register map, in word indices

  // write side
  localparam int WR_PS_FIFO_BASE  = 0;
  localparam int WR_CTRL_BASE     = 2;

  // read side
  localparam int RD_PL_FIFO_BASE  = 0;
  localparam int RD_PL_COUNT_BASE = 2;
  localparam int RD_PS_SPACE_BASE = 4;
  localparam int RD_CTRL_BASE     = 6;
  localparam int RD_STAT_BASE     = 11;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic                   valid;
    logic [WORD_ADDR_W-1:0] addr;
    axil_word_t             data;
  } reg_wr_s;

  typedef struct packed {
    logic                   valid;
    logic [WORD_ADDR_W-1:0] addr;
  } reg_rd_s;

  typedef struct packed {
    axil_word_t data;
    logic [1:0] resp;
  } reg_rsp_s;

  //////////////////////////////////////////////////
  // machine descriptor rom

  localparam int ROM_ELS    = 8;
  localparam int ROM_ADDR_W = 3;

  localparam axil_word_t config_rom_c [ROM_ELS] = '{
    32'h0002_0001,  // descriptor format version
    32'h4842_5a31,  // machine id
    32'h0004_0004,  // tiles x / tiles y
    32'h0000_0001,  // pods
    32'h0000_0800,  // dmem words
    32'h0004_0040,  // cache ways / sets
    32'h1000_0000,  // dram size in bytes
    32'h0000_0003   // reset delay stages
  };

endpackage

//--- shell_fifo.sv
`timescale 1ns/1ps

module shell_fifo
  import zynq_shell_pkg::*;
  #(
    parameter int FIFO_ELS = 4,
    parameter int CNT_W    = 3
  )
  (
    input  logic             aclk,
    input  logic             rst_n_i,
    input  axil_word_t       data_i,
    input  logic             v_i,
    output logic             ready_o,
    output axil_word_t       data_o,
    output logic             v_o,
    input  logic             yumi_i,
    output logic [CNT_W-1:0] count_o
  );

  localparam int PTR_W = (FIFO_ELS > 1) ? $clog2(FIFO_ELS) : 1;

  axil_word_t       mem_r [FIFO_ELS];
  logic [PTR_W-1:0] head_r;
  logic [PTR_W-1:0] tail_r;
  logic [CNT_W-1:0] count_r;
  logic             push;
  logic             pop;

  // wraps at FIFO_ELS, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_ELS - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign ready_o = (count_r != CNT_W'(FIFO_ELS));
  assign v_o     = (count_r != '0);
  assign push    = v_i & ready_o;
  assign pop     = yumi_i & v_o;
  assign data_o  = mem_r[head_r];
  assign count_o = count_r;

  always_ff @(posedge aclk)
  begin
    if (!rst_n_i)
    begin
      head_r  <= '0;
      tail_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      if (push)
        tail_r <= ptr_next(tail_r);
      if (pop)
        head_r <= ptr_next(head_r);
      count_r <= count_r + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge aclk)
  begin
    if (push)
      mem_r[tail_r] <= data_i;
  end

endmodule

//--- axil_slave.sv
`timescale 1ns/1ps

module axil_slave
  import zynq_shell_pkg::*;
  (
    input  logic                     aclk,
    input  logic                     rst_n_i,

    // write address and data channels
    input  logic [AXIL_ADDR_W-1:0]   s_axi_awaddr_i,
    input  logic                     s_axi_awvalid_i,
    output logic                     s_axi_awready_o,
    input  axil_word_t               s_axi_wdata_i,
    // byte strobes are not honored, every write is a full word
    input  logic [AXIL_DATA_W/8-1:0] s_axi_wstrb_i,
    input  logic                     s_axi_wvalid_i,
    output logic                     s_axi_wready_o,

    // write response channel
    output logic [1:0]               s_axi_bresp_o,
    output logic                     s_axi_bvalid_o,
    input  logic                     s_axi_bready_i,

    // read address channel
    input  logic [AXIL_ADDR_W-1:0]   s_axi_araddr_i,
    input  logic                     s_axi_arvalid_i,
    output logic                     s_axi_arready_o,

    // read data channel
    output axil_word_t               s_axi_rdata_o,
    output logic [1:0]               s_axi_rresp_o,
    output logic                     s_axi_rvalid_o,
    input  logic                     s_axi_rready_i,

    // register side
    output reg_wr_s                  reg_wr_o,
    output reg_rd_s                  reg_rd_o,
    input  reg_rsp_s                 wr_rsp_i,
    input  reg_rsp_s                 rd_rsp_i
  );

  logic       awready_r;
  logic       wr_fire;
  logic       bvalid_r;
  logic [1:0] bresp_r;

  logic       arready_r;
  logic       rd_fire;
  logic       rvalid_r;
  axil_word_t rdata_r;
  logic [1:0] rresp_r;

  //////////////////////////////////////////////////
  // write path

  // address and data are taken together in the single ready cycle
  assign wr_fire = awready_r & s_axi_awvalid_i & s_axi_wvalid_i;

  always_ff @(posedge aclk)
  begin
    if (!rst_n_i)
    begin
      awready_r <= 1'b0;
      bvalid_r  <= 1'b0;
    end
    else
    begin
      awready_r <= s_axi_awvalid_i & s_axi_wvalid_i & ~bvalid_r & ~awready_r;
      if (wr_fire)
        bvalid_r <= 1'b1;
      else if (s_axi_bready_i)
        bvalid_r <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (wr_fire)
      bresp_r <= wr_rsp_i.resp;
  end

  assign reg_wr_o = '{valid: wr_fire,
                      addr:  s_axi_awaddr_i[AXIL_ADDR_W-1:2],
                      data:  s_axi_wdata_i};

  assign s_axi_awready_o = awready_r;
  assign s_axi_wready_o  = awready_r;
  assign s_axi_bvalid_o  = bvalid_r;
  assign s_axi_bresp_o   = bresp_r;

  //////////////////////////////////////////////////
  // read path

  assign rd_fire = arready_r & s_axi_arvalid_i;

  always_ff @(posedge aclk)
  begin
    if (!rst_n_i)
    begin
      arready_r <= 1'b0;
      rvalid_r  <= 1'b0;
    end
    else
    begin
      arready_r <= s_axi_arvalid_i & ~rvalid_r & ~arready_r;
      if (rd_fire)
        rvalid_r <= 1'b1;
      else if (s_axi_rready_i)
        rvalid_r <= 1'b0;
    end
  end

  // response held until the master takes it
  always_ff @(posedge aclk)
  begin
    if (rd_fire)
    begin
      rdata_r <= rd_rsp_i.data;
      rresp_r <= rd_rsp_i.resp;
    end
  end

  assign reg_rd_o = '{valid: rd_fire,
                      addr:  s_axi_araddr_i[AXIL_ADDR_W-1:2]};

  assign s_axi_arready_o = arready_r;
  assign s_axi_rvalid_o  = rvalid_r;
  assign s_axi_rdata_o   = rdata_r;
  assign s_axi_rresp_o   = rresp_r;

endmodule

//--- pl_shell_regs.sv
`timescale 1ns/1ps

module pl_shell_regs
  import zynq_shell_pkg::*;
  #(
    parameter int FIFO_ELS = 4,
    parameter int CNT_W    = 3
  )
  (
    input  logic                            aclk,
    input  logic                            rst_n_i,

    input  reg_wr_s                         reg_wr_i,
    input  reg_rd_s                         reg_rd_i,
    output reg_rsp_s                        wr_rsp_o,
    output reg_rsp_s                        rd_rsp_o,

    input  axil_word_t [NUM_STAT_REGS-1:0]  stat_i,
    output axil_word_t [NUM_CTRL_REGS-1:0]  ctrl_o,
    output logic [NUM_CTRL_REGS-1:0]        ctrl_new_o,

    input  axil_word_t [NUM_FIFOS-1:0]      pl_fifo_data_i,
    input  logic [NUM_FIFOS-1:0]            pl_fifo_v_i,
    output logic [NUM_FIFOS-1:0]            pl_fifo_ready_o,

    output axil_word_t [NUM_FIFOS-1:0]      ps_fifo_data_o,
    output logic [NUM_FIFOS-1:0]            ps_fifo_v_o,
    input  logic [NUM_FIFOS-1:0]            ps_fifo_yumi_i
  );

  axil_word_t [NUM_CTRL_REGS-1:0]  ctrl_r;

  logic [NUM_FIFOS-1:0]            ps_push;
  logic [NUM_FIFOS-1:0]            ps_ready;
  logic [NUM_FIFOS-1:0][CNT_W-1:0] ps_count;

  axil_word_t [NUM_FIFOS-1:0]      pl_head;
  logic [NUM_FIFOS-1:0]            pl_v;
  logic [NUM_FIFOS-1:0]            pl_pop;
  logic [NUM_FIFOS-1:0][CNT_W-1:0] pl_count;

  //////////////////////////////////////////////////
  // write decode

  always_comb
  begin
    wr_rsp_o   = '{data: '0, resp: RESP_OKAY};
    ps_push    = '0;
    ctrl_new_o = '0;
    for (int i = 0; i < NUM_FIFOS; i++)
    begin
      if (reg_wr_i.addr == WORD_ADDR_W'(WR_PS_FIFO_BASE + i))
      begin
        ps_push[i] = reg_wr_i.valid;
        // full fifo drops the word
        if (!ps_ready[i])
          wr_rsp_o.resp = RESP_SLVERR;
      end
    end
    for (int i = 0; i < NUM_CTRL_REGS; i++)
    begin
      if (reg_wr_i.addr == WORD_ADDR_W'(WR_CTRL_BASE + i))
        ctrl_new_o[i] = reg_wr_i.valid;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!rst_n_i)
      ctrl_r <= '0;
    else
    begin
      for (int i = 0; i < NUM_CTRL_REGS; i++)
      begin
        if (ctrl_new_o[i])
          ctrl_r[i] <= reg_wr_i.data;
      end
    end
  end

  assign ctrl_o = ctrl_r;

  //////////////////////////////////////////////////
  // read decode, unmapped words return zero

  always_comb
  begin
    rd_rsp_o = '{data: '0, resp: RESP_OKAY};
    pl_pop   = '0;
    for (int i = 0; i < NUM_FIFOS; i++)
    begin
      if (reg_rd_i.addr == WORD_ADDR_W'(RD_PL_FIFO_BASE + i))
      begin
        if (pl_v[i])
        begin
          rd_rsp_o.data = pl_head[i];
          pl_pop[i]     = reg_rd_i.valid;
        end
        else
          rd_rsp_o.resp = RESP_SLVERR;
      end
      if (reg_rd_i.addr == WORD_ADDR_W'(RD_PL_COUNT_BASE + i))
        rd_rsp_o.data = AXIL_DATA_W'(pl_count[i]);
      if (reg_rd_i.addr == WORD_ADDR_W'(RD_PS_SPACE_BASE + i))
        rd_rsp_o.data = AXIL_DATA_W'(FIFO_ELS) - AXIL_DATA_W'(ps_count[i]);
    end
    for (int i = 0; i < NUM_CTRL_REGS; i++)
    begin
      if (reg_rd_i.addr == WORD_ADDR_W'(RD_CTRL_BASE + i))
        rd_rsp_o.data = ctrl_r[i];
    end
    for (int i = 0; i < NUM_STAT_REGS; i++)
    begin
      if (reg_rd_i.addr == WORD_ADDR_W'(RD_STAT_BASE + i))
        rd_rsp_o.data = stat_i[i];
    end
  end

  //////////////////////////////////////////////////
  // fifos

  for (genvar i = 0; i < NUM_FIFOS; i++)
  begin : g_ps_fifo
    shell_fifo #(
      .FIFO_ELS (FIFO_ELS),
      .CNT_W    (CNT_W)
    ) ps_fifo (
      .aclk     (aclk),
      .rst_n_i  (rst_n_i),
      .data_i   (reg_wr_i.data),
      .v_i      (ps_push[i]),
      .ready_o  (ps_ready[i]),
      .data_o   (ps_fifo_data_o[i]),
      .v_o      (ps_fifo_v_o[i]),
      .yumi_i   (ps_fifo_yumi_i[i]),
      .count_o  (ps_count[i])
    );
  end

  for (genvar i = 0; i < NUM_FIFOS; i++)
  begin : g_pl_fifo
    shell_fifo #(
      .FIFO_ELS (FIFO_ELS),
      .CNT_W    (CNT_W)
    ) pl_fifo (
      .aclk     (aclk),
      .rst_n_i  (rst_n_i),
      .data_i   (pl_fifo_data_i[i]),
      .v_i      (pl_fifo_v_i[i]),
      .ready_o  (pl_fifo_ready_o[i]),
      .data_o   (pl_head[i]),
      .v_o      (pl_v[i]),
      .yumi_i   (pl_pop[i]),
      .count_o  (pl_count[i])
    );
  end

endmodule

//--- machine_ctrl.sv
`timescale 1ns/1ps

module machine_ctrl
  import zynq_shell_pkg::*;
  #(
    parameter int RESET_DEPTH = 3
  )
  (
    input  logic                           aclk,
    input  logic                           rst_n_i,
    input  axil_word_t [NUM_CTRL_REGS-1:0] ctrl_i,
    input  logic [NUM_CTRL_REGS-1:0]       ctrl_new_i,
    output logic                           core_reset_o,
    output logic                           bb_data_o,
    output logic                           bb_v_o,
    output logic                           dram_init_o,
    output axil_word_t                     dram_base_o,
    output axil_word_t                     rom_data_o
  );

  // control register roles
  localparam int CTRL_RESET     = 0;
  localparam int CTRL_BB        = 1;
  localparam int CTRL_DRAM_INIT = 2;
  localparam int CTRL_DRAM_BASE = 3;
  localparam int CTRL_ROM_ADDR  = 4;

  logic [RESET_DEPTH-1:0] reset_chain_r;
  logic                   bb_v_r;
  logic [ROM_ADDR_W-1:0]  rom_addr;

  //////////////////////////////////////////////////
  // core reset delay chain

  // register bit is an active-low reset, chain starts asserted
  always_ff @(posedge aclk)
  begin
    if (!rst_n_i)
      reset_chain_r <= '1;
    else
    begin
      reset_chain_r[0] <= ~ctrl_i[CTRL_RESET][0];
      for (int i = 1; i < RESET_DEPTH; i++)
        reset_chain_r[i] <= reset_chain_r[i-1];
    end
  end

  assign core_reset_o = reset_chain_r[RESET_DEPTH-1];

  // one pulse per write, lines up with the new register value
  always_ff @(posedge aclk)
  begin
    if (!rst_n_i)
      bb_v_r <= 1'b0;
    else
      bb_v_r <= ctrl_new_i[CTRL_BB];
  end

  assign bb_v_o      = bb_v_r;
  assign bb_data_o   = ctrl_i[CTRL_BB][0];
  assign dram_init_o = ctrl_i[CTRL_DRAM_INIT][0];
  assign dram_base_o = ctrl_i[CTRL_DRAM_BASE];

  assign rom_addr    = ctrl_i[CTRL_ROM_ADDR][ROM_ADDR_W-1:0];
  assign rom_data_o  = config_rom_c[rom_addr];

endmodule

//--- top_zynq.sv
`timescale 1ns/1ps

module top_zynq
  import zynq_shell_pkg::*;
  #(
    parameter int FIFO_ELS    = 4,
    parameter int RESET_DEPTH = 3
  )
  (
    input  logic                       aclk,
    input  logic                       rst_n_i,

    // axi4-lite slave from the ps
    input  logic [AXIL_ADDR_W-1:0]     s_axi_awaddr_i,
    input  logic                       s_axi_awvalid_i,
    output logic                       s_axi_awready_o,
    input  axil_word_t                 s_axi_wdata_i,
    input  logic [AXIL_DATA_W/8-1:0]   s_axi_wstrb_i,
    input  logic                       s_axi_wvalid_i,
    output logic                       s_axi_wready_o,
    output logic [1:0]                 s_axi_bresp_o,
    output logic                       s_axi_bvalid_o,
    input  logic                       s_axi_bready_i,
    input  logic [AXIL_ADDR_W-1:0]     s_axi_araddr_i,
    input  logic                       s_axi_arvalid_i,
    output logic                       s_axi_arready_o,
    output axil_word_t                 s_axi_rdata_o,
    output logic [1:0]                 s_axi_rresp_o,
    output logic                       s_axi_rvalid_o,
    input  logic                       s_axi_rready_i,

    // external status word
    input  axil_word_t                 stat_i,

    // fifo endpoints
    output axil_word_t [NUM_FIFOS-1:0] ps_fifo_data_o,
    output logic [NUM_FIFOS-1:0]       ps_fifo_v_o,
    input  logic [NUM_FIFOS-1:0]       ps_fifo_yumi_i,
    input  axil_word_t [NUM_FIFOS-1:0] pl_fifo_data_i,
    input  logic [NUM_FIFOS-1:0]       pl_fifo_v_i,
    output logic [NUM_FIFOS-1:0]       pl_fifo_ready_o,

    // machine control
    output logic                       core_reset_o,
    output logic                       bb_data_o,
    output logic                       bb_v_o,
    output logic                       dram_init_o,
    output axil_word_t                 dram_base_o
  );

  localparam int CNT_W = $clog2(FIFO_ELS + 1);

  reg_wr_s                        reg_wr;
  reg_rd_s                        reg_rd;
  reg_rsp_s                       wr_rsp;
  reg_rsp_s                       rd_rsp;
  axil_word_t [NUM_CTRL_REGS-1:0] ctrl;
  logic [NUM_CTRL_REGS-1:0]       ctrl_new;
  axil_word_t [NUM_STAT_REGS-1:0] stat_words;
  axil_word_t                     rom_data;

  // status 1 reads the rom entry selected by control 4
  assign stat_words[0] = stat_i;
  assign stat_words[1] = rom_data;

  axil_slave axil (
    .aclk            (aclk),
    .rst_n_i         (rst_n_i),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .reg_wr_o        (reg_wr),
    .reg_rd_o        (reg_rd),
    .wr_rsp_i        (wr_rsp),
    .rd_rsp_i        (rd_rsp)
  );

  pl_shell_regs #(
    .FIFO_ELS (FIFO_ELS),
    .CNT_W    (CNT_W)
  ) regs (
    .aclk            (aclk),
    .rst_n_i         (rst_n_i),
    .reg_wr_i        (reg_wr),
    .reg_rd_i        (reg_rd),
    .wr_rsp_o        (wr_rsp),
    .rd_rsp_o        (rd_rsp),
    .stat_i          (stat_words),
    .ctrl_o          (ctrl),
    .ctrl_new_o      (ctrl_new),
    .pl_fifo_data_i  (pl_fifo_data_i),
    .pl_fifo_v_i     (pl_fifo_v_i),
    .pl_fifo_ready_o (pl_fifo_ready_o),
    .ps_fifo_data_o  (ps_fifo_data_o),
    .ps_fifo_v_o     (ps_fifo_v_o),
    .ps_fifo_yumi_i  (ps_fifo_yumi_i)
  );

  machine_ctrl #(
    .RESET_DEPTH (RESET_DEPTH)
  ) mctrl (
    .aclk         (aclk),
    .rst_n_i      (rst_n_i),
    .ctrl_i       (ctrl),
    .ctrl_new_i   (ctrl_new),
    .core_reset_o (core_reset_o),
    .bb_data_o    (bb_data_o),
    .bb_v_o       (bb_v_o),
    .dram_init_o  (dram_init_o),
    .dram_base_o  (dram_base_o),
    .rom_data_o   (rom_data)
  );

endmodule

//--- tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

//////////////////////////////////////////////////
// axi4-lite master side, one transfer at a time

// single write; wr_hs_cycle records the AWREADY/WREADY handshake edge
task automatic write_word(input int word, input axil_word_t data, output logic [1:0] resp);
  int waited;
  awaddr  <= AXIL_ADDR_W'(word * 4);
  awvalid <= 1'b1;
  wdata   <= data;
  wstrb   <= '1;
  wvalid  <= 1'b1;
  waited  = 0;
  do
  begin
    @(posedge aclk);
    waited++;
  end
  while (!awready && waited < HS_LIMIT);
  awvalid <= 1'b0;
  wvalid  <= 1'b0;
  if (!awready)
  begin
    report_stall($sformatf("write to word %0d was never accepted by the slave", word));
    resp = 2'bxx;
    return;
  end
  wr_hs_cycle = cycle;
  bready <= 1'b1;
  waited = 0;
  do
  begin
    @(posedge aclk);
    waited++;
  end
  while (!bvalid && waited < HS_LIMIT);
  resp = bresp;
  bready <= 1'b0;
  if (!bvalid)
    report_stall($sformatf("no write response for word %0d", word));
endtask

// single read, data and RRESP taken in the RVALID cycle
task automatic read_word(input int word, output axil_word_t data, output logic [1:0] resp);
  int waited;
  araddr  <= AXIL_ADDR_W'(word * 4);
  arvalid <= 1'b1;
  waited  = 0;
  do
  begin
    @(posedge aclk);
    waited++;
  end
  while (!arready && waited < HS_LIMIT);
  arvalid <= 1'b0;
  if (!arready)
  begin
    report_stall($sformatf("read of word %0d was never accepted by the slave", word));
    data = 'x;
    resp = 2'bxx;
    return;
  end
  rready <= 1'b1;
  waited = 0;
  do
  begin
    @(posedge aclk);
    waited++;
  end
  while (!rvalid && waited < HS_LIMIT);
  data = rdata;
  resp = rresp;
  rready <= 1'b0;
  if (!rvalid)
    report_stall($sformatf("no read data for word %0d", word));
endtask

`endif

//--- tb_top_zynq.sv
`timescale 1ns/1ps

module tb_top_zynq
  import zynq_shell_pkg::*;
  ();

  localparam int FIFO_ELS    = 4;
  localparam int RESET_DEPTH = 3;
  localparam int CLK_PERIOD  = 20;
  localparam int HS_LIMIT    = 16;
  // about 400 cycles of traffic over all tests, five times that as margin
  localparam int EST_CYCLES  = 400;
  localparam int MAX_CYCLES  = 5 * EST_CYCLES;

  logic                       aclk;
  logic                       rst_n;
  logic [AXIL_ADDR_W-1:0]     awaddr;
  logic                       awvalid;
  logic                       awready;
  axil_word_t                 wdata;
  logic [AXIL_DATA_W/8-1:0]   wstrb;
  logic                       wvalid;
  logic                       wready;
  logic [1:0]                 bresp;
  logic                       bvalid;
  logic                       bready;
  logic [AXIL_ADDR_W-1:0]     araddr;
  logic                       arvalid;
  logic                       arready;
  axil_word_t                 rdata;
  logic [1:0]                 rresp;
  logic                       rvalid;
  logic                       rready;
  axil_word_t                 stat;
  axil_word_t [NUM_FIFOS-1:0] ps_fifo_data;
  logic [NUM_FIFOS-1:0]       ps_fifo_v;
  logic [NUM_FIFOS-1:0]       ps_fifo_yumi;
  axil_word_t [NUM_FIFOS-1:0] pl_fifo_data;
  logic [NUM_FIFOS-1:0]       pl_fifo_v;
  logic [NUM_FIFOS-1:0]       pl_fifo_ready;
  logic                       core_reset;
  logic                       bb_data;
  logic                       bb_v;
  logic                       dram_init;
  axil_word_t                 dram_base;

  int         cycle = 0;
  int         err_cnt = 0;
  int         test_err_base = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         bb_pulses = 0;
  int         wr_hs_cycle = 0;
  string      test_name;
  axil_word_t lcg_state;

  logic       wr_hs;
  logic       bb_wr_hs;

  top_zynq #(
    .FIFO_ELS    (FIFO_ELS),
    .RESET_DEPTH (RESET_DEPTH)
  ) dut_i (
    .aclk            (aclk),
    .rst_n_i         (rst_n),
    .s_axi_awaddr_i  (awaddr),
    .s_axi_awvalid_i (awvalid),
    .s_axi_awready_o (awready),
    .s_axi_wdata_i   (wdata),
    .s_axi_wstrb_i   (wstrb),
    .s_axi_wvalid_i  (wvalid),
    .s_axi_wready_o  (wready),
    .s_axi_bresp_o   (bresp),
    .s_axi_bvalid_o  (bvalid),
    .s_axi_bready_i  (bready),
    .s_axi_araddr_i  (araddr),
    .s_axi_arvalid_i (arvalid),
    .s_axi_arready_o (arready),
    .s_axi_rdata_o   (rdata),
    .s_axi_rresp_o   (rresp),
    .s_axi_rvalid_o  (rvalid),
    .s_axi_rready_i  (rready),
    .stat_i          (stat),
    .ps_fifo_data_o  (ps_fifo_data),
    .ps_fifo_v_o     (ps_fifo_v),
    .ps_fifo_yumi_i  (ps_fifo_yumi),
    .pl_fifo_data_i  (pl_fifo_data),
    .pl_fifo_v_i     (pl_fifo_v),
    .pl_fifo_ready_o (pl_fifo_ready),
    .core_reset_o    (core_reset),
    .bb_data_o       (bb_data),
    .bb_v_o          (bb_v),
    .dram_init_o     (dram_init),
    .dram_base_o     (dram_base)
  );

  initial
  begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  always @(posedge aclk)
  begin
    cycle <= cycle + 1;
    if (bb_v)
      bb_pulses <= bb_pulses + 1;
  end

  //////////////////////////////////////////////////
  // helpers

  function automatic axil_word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic mark_error(input string msg);
    err_cnt++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic report_stall(input string msg);
    err_cnt++;
    $display("bus handshake stalled at %0t: %s", $time, msg);
  endtask

  task automatic check_eq(input string what, input axil_word_t got, input axil_word_t exp);
    assert (got === exp)
    else
      mark_error($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = err_cnt;
    tests_run++;
  endtask

  task automatic finish_test();
    if (err_cnt == test_err_base)
      $display("test %0d %s: ok", tests_run, test_name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, test_name, err_cnt - test_err_base);
    end
  endtask

  `include "tb_axil_tasks.svh"

  //////////////////////////////////////////////////
  // protocol and bit-bang properties

  assign wr_hs    = awready & awvalid & wvalid;
  assign bb_wr_hs = wr_hs & (awaddr[AXIL_ADDR_W-1:2] == WORD_ADDR_W'(WR_CTRL_BASE + 1));

  ready_pair: assert property (@(posedge aclk) disable iff (!rst_n)
    awready == wready)
    else mark_error("AWREADY and WREADY differ");

  write_backpressure: assert property (@(posedge aclk) disable iff (!rst_n)
    bvalid |-> !awready)
    else mark_error("write accepted while BVALID is high");

  read_backpressure: assert property (@(posedge aclk) disable iff (!rst_n)
    rvalid |-> !arready)
    else mark_error("read accepted while RVALID is high");

  bb_pulse_on_write: assert property (@(posedge aclk) disable iff (!rst_n)
    bb_wr_hs |=> (bb_v && bb_data == $past(wdata[0])))
    else mark_error("bb_v_o/bb_data_o wrong after a write to control 1");

  bb_quiet_otherwise: assert property (@(posedge aclk) disable iff (!rst_n)
    !bb_wr_hs |=> !bb_v)
    else mark_error("bb_v_o pulse without a write to control 1");

  initial
  begin
    wait (cycle >= MAX_CYCLES);
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [1:0] resp;
    axil_word_t rd;
    axil_word_t d2;
    axil_word_t d3;
    axil_word_t word_v;
    axil_word_t q[$];
    int         waited;
    int         pulses_before;
    int         n_bb;

    lcg_state = 32'hb081_78d3;
    rst_n        <= 1'b0;
    awaddr       <= '0;
    awvalid      <= 1'b0;
    wdata        <= '0;
    wstrb        <= '0;
    wvalid       <= 1'b0;
    bready       <= 1'b0;
    araddr       <= '0;
    arvalid      <= 1'b0;
    rready       <= 1'b0;
    stat         <= '0;
    ps_fifo_yumi <= '0;
    pl_fifo_data <= '0;
    pl_fifo_v    <= '0;
    repeat (4) @(posedge aclk);
    rst_n <= 1'b1;
    @(posedge aclk);

    start_test("reset state");
    assert (core_reset === 1'b1 && bb_v === 1'b0 && dram_init === 1'b0)
    else
      mark_error("control outputs not at their reset values");
    assert (!awready && !wready && !arready && !bvalid && !rvalid)
    else
      mark_error("bus handshake outputs active after reset");
    assert (ps_fifo_v === '0 && pl_fifo_ready === '1)
    else
      mark_error("fifo strobes not at their reset values");
    for (int i = 0; i < NUM_CTRL_REGS; i++)
    begin
      read_word(RD_CTRL_BASE + i, rd, resp);
      check_eq($sformatf("control %0d after reset", i), rd, '0);
    end
    finish_test();

    start_test("control registers");
    // bit 0 set so dram_init_o has to leave its reset level
    d2 = lcg_next() | 32'd1;
    d3 = lcg_next();
    write_word(WR_CTRL_BASE + 2, d2, resp);
    check_eq("control 2 write response", resp, RESP_OKAY);
    write_word(WR_CTRL_BASE + 3, d3, resp);
    check_eq("control 3 write response", resp, RESP_OKAY);
    read_word(RD_CTRL_BASE + 2, rd, resp);
    check_eq("control 2 readback", rd, d2);
    read_word(RD_CTRL_BASE + 3, rd, resp);
    check_eq("control 3 readback", rd, d3);
    check_eq("dram_init_o", dram_init, d2[0]);
    check_eq("dram_base_o", dram_base, d3);
    write_word(WR_CTRL_BASE, 32'd1, resp);
    // a change made at edge n is first sampled at edge n+1
    waited = 0;
    while (core_reset === 1'b1 && waited < 4 * RESET_DEPTH + 4)
    begin
      @(posedge aclk);
      waited++;
    end
    check_eq("core_reset_o delay", cycle - wr_hs_cycle - 1, RESET_DEPTH);
    finish_test();

    start_test("ps to pl fifo");
    q.delete();
    for (int i = 0; i < FIFO_ELS; i++)
    begin
      word_v = lcg_next();
      q.push_back(word_v);
      write_word(WR_PS_FIFO_BASE, word_v, resp);
      check_eq("push response", resp, RESP_OKAY);
      read_word(RD_PS_SPACE_BASE, rd, resp);
      check_eq("free slots", rd, FIFO_ELS - i - 1);
    end
    write_word(WR_PS_FIFO_BASE, lcg_next(), resp);
    check_eq("push into full fifo", resp, RESP_SLVERR);
    while (q.size() > 0)
    begin
      repeat (1 + (lcg_next() >> 16) % 3) @(posedge aclk);
      assert (ps_fifo_v[0] === 1'b1)
      else
        mark_error("ps fifo 0 empty while words remain");
      check_eq("ps fifo 0 head", ps_fifo_data[0], q.pop_front());
      if (ps_fifo_v[0])
        ps_fifo_yumi[0] <= 1'b1;
      @(posedge aclk);
      ps_fifo_yumi[0] <= 1'b0;
    end
    @(posedge aclk);
    assert (ps_fifo_v[0] === 1'b0)
    else
      mark_error("ps fifo 0 still valid after drain");
    read_word(RD_PS_SPACE_BASE, rd, resp);
    check_eq("free slots after drain", rd, FIFO_ELS);
    finish_test();

    start_test("pl to ps fifo");
    q.delete();
    for (int i = 0; i < FIFO_ELS; i++)
    begin
      word_v = lcg_next();
      q.push_back(word_v);
      pl_fifo_data[1] <= word_v;
      pl_fifo_v[1]    <= 1'b1;
      @(posedge aclk);
      assert (pl_fifo_ready[1] === 1'b1)
      else
        mark_error("pl fifo 1 refused a push below its depth");
    end
    pl_fifo_v[1] <= 1'b0;
    @(posedge aclk);
    assert (pl_fifo_ready[1] === 1'b0)
    else
      mark_error("pl fifo 1 ready while full");
    for (int i = 0; i < FIFO_ELS; i++)
    begin
      read_word(RD_PL_COUNT_BASE + 1, rd, resp);
      check_eq("pl fifo 1 count", rd, FIFO_ELS - i);
      read_word(RD_PL_FIFO_BASE + 1, rd, resp);
      check_eq("pl fifo 1 data", rd, q.pop_front());
      check_eq("pl fifo 1 pop response", resp, RESP_OKAY);
    end
    read_word(RD_PL_FIFO_BASE + 1, rd, resp);
    check_eq("empty pop data", rd, '0);
    check_eq("empty pop response", resp, RESP_SLVERR);
    finish_test();

    start_test("config rom and status");
    for (int a = 0; a < ROM_ELS; a++)
    begin
      // random upper bits, only the address modulo ROM_ELS selects
      word_v = (lcg_next() / ROM_ELS) * ROM_ELS + a;
      write_word(WR_CTRL_BASE + 4, word_v, resp);
      read_word(RD_STAT_BASE + 1, rd, resp);
      check_eq($sformatf("rom entry %0d", a), rd, config_rom_c[a]);
    end
    word_v = lcg_next();
    stat <= word_v;
    @(posedge aclk);
    read_word(RD_STAT_BASE, rd, resp);
    check_eq("status 0", rd, word_v);
    finish_test();

    start_test("tag bit-bang");
    pulses_before = bb_pulses;
    n_bb = 0;
    for (int i = 0; i < 4; i++)
    begin
      // bit 0 alternates so bb_data_o is seen at both levels
      word_v    = lcg_next();
      word_v[0] = i[0];
      write_word(WR_CTRL_BASE + 1, word_v, resp);
      n_bb++;
      write_word(WR_CTRL_BASE + 2, lcg_next(), resp);
    end
    repeat (2) @(posedge aclk);
    check_eq("bb_v_o pulse count", bb_pulses - pulses_before, n_bb);
    finish_test();

    start_test("bus back-pressure");
    d2 = lcg_next();
    d3 = lcg_next();
    awaddr  <= AXIL_ADDR_W'((WR_CTRL_BASE + 2) * 4);
    wdata   <= d2;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    waited = 0;
    do
    begin
      @(posedge aclk);
      waited++;
    end
    while (!awready && waited < HS_LIMIT);
    // second write offered while the first response is still pending
    awaddr <= AXIL_ADDR_W'((WR_CTRL_BASE + 3) * 4);
    wdata  <= d3;
    repeat (4) @(posedge aclk);
    assert (bvalid === 1'b1 && awready === 1'b0)
    else
      mark_error("write response not held while BREADY is low");
    bready <= 1'b1;
    waited = 0;
    do
    begin
      @(posedge aclk);
      waited++;
    end
    while (!awready && waited < HS_LIMIT);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    waited = 0;
    do
    begin
      @(posedge aclk);
      waited++;
    end
    while (!bvalid && waited < HS_LIMIT);
    bready <= 1'b0;
    if (!bvalid)
      report_stall("no response for the write held back by BVALID");
    read_word(RD_CTRL_BASE + 2, rd, resp);
    check_eq("first write under back-pressure", rd, d2);
    read_word(RD_CTRL_BASE + 3, rd, resp);
    check_eq("second write under back-pressure", rd, d3);

    araddr  <= AXIL_ADDR_W'((RD_CTRL_BASE + 2) * 4);
    arvalid <= 1'b1;
    waited = 0;
    do
    begin
      @(posedge aclk);
      waited++;
    end
    while (!arready && waited < HS_LIMIT);
    // second read offered while the first data is still pending
    araddr <= AXIL_ADDR_W'((RD_CTRL_BASE + 3) * 4);
    repeat (4) @(posedge aclk);
    assert (rvalid === 1'b1 && arready === 1'b0)
    else
      mark_error("read data not held while RREADY is low");
    check_eq("held read data", rdata, d2);
    rready <= 1'b1;
    @(posedge aclk);
    rready <= 1'b0;
    waited = 0;
    do
    begin
      @(posedge aclk);
      waited++;
    end
    while (!arready && waited < HS_LIMIT);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    waited = 0;
    do
    begin
      @(posedge aclk);
      waited++;
    end
    while (!rvalid && waited < HS_LIMIT);
    rready <= 1'b0;
    if (!rvalid)
      report_stall("no data for the read held back by RVALID");
    check_eq("second read under back-pressure", rdata, d3);
    finish_test();

    $display("summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- zynq_shell.f
+incdir+.
zynq_shell_pkg.sv
shell_fifo.sv
axil_slave.sv
pl_shell_regs.sv
machine_ctrl.sv
top_zynq.sv
tb_top_zynq.sv
